// ==== rtl/cpuPkg.sv ====
package cpuPkg;

  // datapath geometry
  localparam int dataWidth = 16;
  localparam int regAddrWidth = 4;
  localparam int numRegs = 16;

  // instruction field widths
  localparam int opWidth = 4;
  localparam int immWidth = 8;     // LLB/LHB immediate, src1 and src2 together
  localparam int shamtWidth = 4;   // shift amount taken from src2

  // saturation limits for ADD/SUB
  localparam logic [dataWidth-1:0] satPos = {1'b0, {(dataWidth - 1){1'b1}}};
  localparam logic [dataWidth-1:0] satNeg = {1'b1, {(dataWidth - 1){1'b0}}};

  // codes follow the full ISA, the slice only executes these
  typedef enum logic [opWidth-1:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    XOR = 4'h2,
    SLL = 4'h4,
    SRA = 4'h5,
    ROR = 4'h6,
    LLB = 4'hA,
    LHB = 4'hB
  } opcode_t;

  typedef struct packed {
    opcode_t                 opcode;
    logic [regAddrWidth-1:0] dst;
    logic [regAddrWidth-1:0] src1;
    logic [regAddrWidth-1:0] src2;
  } instr_t;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
  } flags_t;

  typedef struct packed {
    logic                    en;
    logic [regAddrWidth-1:0] addr;
    logic [dataWidth-1:0]    data;
  } wrBack_t;

endpackage

// ==== rtl/regFile.sv ====
`timescale 1ns/1ns

module regFile (
  input  logic                            clk,
  input  logic                            arstN,
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
  input  cpuPkg::wrBack_t                 wrBack,
  output logic [cpuPkg::dataWidth-1:0]    rdDataA,
  output logic [cpuPkg::dataWidth-1:0]    rdDataB
);
  import cpuPkg::*;

  // r0 has no storage
  logic [dataWidth-1:0] regs [1:numRegs-1];
  logic [numRegs-1:1]   wrSel;   // one-hot write wordlines, none for r0

  // write address decode, one comparator per wordline
  always_comb begin
    for (int i = 1; i < numRegs; i++) begin
      wrSel[i] = wrBack.en && (wrBack.addr == regAddrWidth'(i));
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < numRegs; i++) begin
        if (wrSel[i]) begin
          regs[i] <= wrBack.data;
        end
      end
    end
  end

  // read ports, both combinational
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

  wrSelOneHot: assert property (
    @(posedge clk) disable iff (!arstN)
    $onehot0(wrSel)
  ) else $error("regFile: more than one write enable at %0t", $time);

endmodule

// ==== rtl/flagReg.sv ====
`timescale 1ns/1ns

module flagReg (
  input  logic            clk,
  input  logic            arstN,
  input  logic            issue,
  input  cpuPkg::opcode_t op,
  input  cpuPkg::flags_t  aluFlags,
  output cpuPkg::flags_t  flags
);
  import cpuPkg::*;

  flags_t wrEn;   // one enable per flag, same layout

  always_comb begin
    wrEn = '0;
    if (issue) begin
      case (op)
        ADD, SUB: wrEn = '{n: 1'b1, v: 1'b1, z: 1'b1};
        XOR, SLL, SRA, ROR: wrEn.z = 1'b1;   // logic ops touch z only
        default: wrEn = '0;                   // byte loads keep all flags
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else begin
      if (wrEn.n) begin
        flags.n <= aluFlags.n;
      end
      if (wrEn.v) begin
        flags.v <= aluFlags.v;
      end
      if (wrEn.z) begin
        flags.z <= aluFlags.z;
      end
    end
  end

  idleHoldsFlags: assert property (
    @(posedge clk) disable iff (!arstN)
    !issue |=> $stable(flags)
  ) else $error("flagReg: flags changed without issue at %0t", $time);

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu (
  input  cpuPkg::instr_t               instr,
  input  logic [cpuPkg::dataWidth-1:0] opA,
  input  logic [cpuPkg::dataWidth-1:0] opB,
  output logic [cpuPkg::dataWidth-1:0] result,
  output cpuPkg::flags_t               aluFlags
);
  import cpuPkg::*;

  logic [dataWidth-1:0]        sum;
  logic [dataWidth-1:0]        diff;
  logic                        sumOvf;
  logic                        diffOvf;
  logic                        ovf;
  logic [shamtWidth-1:0]       shamt;
  logic [immWidth-1:0]         imm;
  logic [dataWidth-1:0]        sllOut;
  logic signed [dataWidth-1:0] sraOut;
  logic [2*dataWidth-1:0]      rotWide;

  // clamp on overflow, direction set by the sign of opA
  function automatic logic [dataWidth-1:0] saturate(
    input logic [dataWidth-1:0] raw,
    input logic                 overflow,
    input logic                 negA
  );
    logic [dataWidth-1:0] res;
    res = raw;
    if (overflow) begin
      res = negA ? satNeg : satPos;
    end
    return res;
  endfunction

  assign shamt = instr.src2;
  assign imm   = {instr.src1, instr.src2};

  assign sum  = opA + opB;
  assign diff = opA - opB;

  // signed overflow from operand and result signs
  assign sumOvf  = (opA[dataWidth-1] == opB[dataWidth-1]) &&
                   (sum[dataWidth-1] != opA[dataWidth-1]);
  assign diffOvf = (opA[dataWidth-1] != opB[dataWidth-1]) &&
                   (diff[dataWidth-1] != opA[dataWidth-1]);

  assign sllOut  = opA << shamt;
  assign sraOut  = $signed(opA) >>> shamt;   // sign fill
  assign rotWide = {opA, opA} >> shamt;      // low half is the rotate

  always_comb begin
    result = '0;
    ovf    = 1'b0;
    case (instr.opcode)
      ADD: begin
        result = saturate(sum, sumOvf, opA[dataWidth-1]);
        ovf    = sumOvf;
      end
      SUB: begin
        result = saturate(diff, diffOvf, opA[dataWidth-1]);
        ovf    = diffOvf;
      end
      XOR: result = opA ^ opB;
      SLL: result = sllOut;
      SRA: result = sraOut;
      ROR: result = rotWide[dataWidth-1:0];
      LLB: result = {opA[dataWidth-1:immWidth], imm};
      LHB: result = {imm, opA[immWidth-1:0]};
      default: result = '0;
    endcase
  end

  // v only meaningful for ADD/SUB, flagReg masks the rest
  assign aluFlags.n = result[dataWidth-1];
  assign aluFlags.v = ovf;
  assign aluFlags.z = (result == '0);

  always_comb begin
    opcodeKnown: assert ($isunknown(instr.opcode) ||
                         instr.opcode inside {ADD, SUB, XOR, SLL, SRA, ROR, LLB, LHB})
      else $error("alu: undefined opcode %h at %0t", instr.opcode, $time);
  end

endmodule

// ==== rtl/execCore.sv ====
`timescale 1ns/1ns

module execCore (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         issue,
  input  cpuPkg::instr_t               instr,
  output logic [cpuPkg::dataWidth-1:0] result,
  output cpuPkg::flags_t               flags
);
  import cpuPkg::*;

  logic [regAddrWidth-1:0] rdAddrA;
  logic [regAddrWidth-1:0] rdAddrB;
  logic [dataWidth-1:0]    rdDataA;
  logic [dataWidth-1:0]    rdDataB;
  logic                    isByteLoad;
  flags_t                  aluFlags;
  wrBack_t                 wrBack;

  // byte loads merge into dst, so dst is read through port A
  assign isByteLoad = (instr.opcode == LLB) || (instr.opcode == LHB);
  assign rdAddrA    = isByteLoad ? instr.dst : instr.src1;
  assign rdAddrB    = instr.src2;

  // result lands at the next edge
  assign wrBack = '{en: issue, addr: instr.dst, data: result};

  regFile uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .wrBack  (wrBack),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  alu uAlu (
    .instr    (instr),
    .opA      (rdDataA),
    .opB      (rdDataB),
    .result   (result),
    .aluFlags (aluFlags)
  );

  flagReg uFlagReg (
    .clk      (clk),
    .arstN    (arstN),
    .issue    (issue),
    .op       (instr.opcode),
    .aluFlags (aluFlags),
    .flags    (flags)
  );

  // decode and flag enables agree on byte loads
  byteLoadKeepsFlags: assert property (
    @(posedge clk) disable iff (!arstN)
    issue && isByteLoad |=> $stable(flags)
  ) else $error("execCore: byte load changed flags at %0t", $time);

endmodule

// ==== bench/vectorTable.svh ====
// issue, opcode, dst, src1, src2, expected result, expected {n, v, z} after the edge
// every register reads zero out of reset, idle rows
addRow(1'b0, ADD, 4'h0, 4'h1, 4'h2, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'h3, 4'h4, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'h5, 4'h6, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'h7, 4'h8, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'h9, 4'hA, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'hB, 4'hC, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'hD, 4'hE, 16'h0000, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'hF, 4'h0, 16'h0000, 3'b000);
// z set first so the byte loads can show they keep it
addRow(1'b1, ADD, 4'h0, 4'h0, 4'h0, 16'h0000, 3'b001);
addRow(1'b1, LLB, 4'h1, 4'h3, 4'h4, 16'h0034, 3'b001);
addRow(1'b1, LHB, 4'h1, 4'h1, 4'h2, 16'h1234, 3'b001);
addRow(1'b1, ADD, 4'h2, 4'h1, 4'h0, 16'h1234, 3'b000);
// r0 write dropped
addRow(1'b1, LLB, 4'h0, 4'h5, 4'h6, 16'h0056, 3'b000);
addRow(1'b1, ADD, 4'h3, 4'h0, 4'h0, 16'h0000, 3'b001);
// saturation
addRow(1'b1, LLB, 4'h4, 4'h0, 4'h0, 16'h0000, 3'b001);
addRow(1'b1, LHB, 4'h4, 4'h7, 4'h0, 16'h7000, 3'b001);
addRow(1'b1, ADD, 4'h5, 4'h4, 4'h4, 16'h7FFF, 3'b010);
addRow(1'b1, LHB, 4'h6, 4'h8, 4'h0, 16'h8000, 3'b010);
addRow(1'b1, SUB, 4'h8, 4'h5, 4'h5, 16'h0000, 3'b001);
addRow(1'b1, SUB, 4'h7, 4'h6, 4'h4, 16'h8000, 3'b110);
// n and v stay from the SUB above
addRow(1'b1, XOR, 4'h9, 4'h2, 4'h4, 16'h6234, 3'b110);
addRow(1'b1, XOR, 4'hA, 4'h7, 4'h7, 16'h0000, 3'b111);
addRow(1'b0, XOR, 4'hA, 4'h2, 4'h2, 16'h0000, 3'b111);
addRow(1'b0, ADD, 4'hB, 4'h5, 4'h5, 16'h7FFF, 3'b111);
addRow(1'b1, ADD, 4'hC, 4'hB, 4'h0, 16'h0000, 3'b001);
// shifts and rotate by 0, 1 and 15, n left set by the SUB
addRow(1'b1, SUB, 4'hD, 4'h0, 4'h2, 16'hEDCC, 3'b100);
addRow(1'b1, SLL, 4'hE, 4'h2, 4'h0, 16'h1234, 3'b100);
addRow(1'b1, SLL, 4'hE, 4'hE, 4'h1, 16'h2468, 3'b100);
addRow(1'b1, SLL, 4'hF, 4'h2, 4'hF, 16'h0000, 3'b101);
addRow(1'b1, SRA, 4'hF, 4'h6, 4'h1, 16'hC000, 3'b100);
addRow(1'b1, SRA, 4'hF, 4'hD, 4'hF, 16'hFFFF, 3'b100);
addRow(1'b1, SRA, 4'hE, 4'h2, 4'hF, 16'h0000, 3'b101);
addRow(1'b1, SRA, 4'hE, 4'hD, 4'h0, 16'hEDCC, 3'b100);
addRow(1'b1, ROR, 4'hC, 4'h2, 4'h0, 16'h1234, 3'b100);
addRow(1'b1, ROR, 4'hC, 4'hC, 4'h1, 16'h091A, 3'b100);
addRow(1'b1, ROR, 4'hB, 4'h2, 4'hF, 16'h2468, 3'b100);
addRow(1'b1, ROR, 4'hB, 4'h6, 4'h1, 16'h4000, 3'b100);
addRow(1'b1, ROR, 4'hB, 4'hD, 4'hF, 16'hDB99, 3'b100);
// back to back chain on r1
addRow(1'b1, ADD, 4'h1, 4'h1, 4'h1, 16'h2468, 3'b000);
addRow(1'b1, ADD, 4'h1, 4'h1, 4'h1, 16'h48D0, 3'b000);
addRow(1'b1, ADD, 4'h1, 4'h1, 4'h1, 16'h7FFF, 3'b010);
addRow(1'b1, SUB, 4'h2, 4'h1, 4'h1, 16'h0000, 3'b001);
addRow(1'b1, XOR, 4'h3, 4'h1, 4'h2, 16'h7FFF, 3'b000);
addRow(1'b0, ADD, 4'h0, 4'h3, 4'h0, 16'h7FFF, 3'b000);
addRow(1'b1, LLB, 4'h5, 4'hC, 4'h3, 16'h7FC3, 3'b000);
addRow(1'b1, LHB, 4'h5, 4'h0, 4'h1, 16'h01C3, 3'b000);
addRow(1'b1, SUB, 4'h6, 4'h0, 4'h5, 16'hFE3D, 3'b100);
addRow(1'b1, SRA, 4'h7, 4'h6, 4'h1, 16'hFF1E, 3'b100);
addRow(1'b1, SLL, 4'h8, 4'h6, 4'hF, 16'h8000, 3'b100);
addRow(1'b1, ROR, 4'h9, 4'h5, 4'h0, 16'h01C3, 3'b100);
addRow(1'b1, ADD, 4'hA, 4'h6, 4'h6, 16'hFC7A, 3'b100);
addRow(1'b1, LLB, 4'h0, 4'hF, 4'hF, 16'h00FF, 3'b100);
addRow(1'b1, ADD, 4'hB, 4'h0, 4'h0, 16'h0000, 3'b001);
addRow(1'b0, ADD, 4'h0, 4'h6, 4'h5, 16'h0000, 3'b001);
addRow(1'b1, XOR, 4'hC, 4'h6, 4'h7, 16'h0123, 3'b000);

// ==== bench/execCoreTb.sv ====
`timescale 1ns/1ns

module execCoreTb;
  import cpuPkg::*;

  localparam int halfPeriod = 10;
  localparam int resetCycles = 5;
  localparam int releaseTimeout = 20;   // cycles

  typedef struct packed {
    logic                 issue;
    instr_t               instr;
    logic [dataWidth-1:0] expResult;
    flags_t               expFlags;   // after this row's edge
  } vector_t;

  logic                 clk;
  logic                 arstN;
  logic                 issue;
  instr_t               instr;
  logic [dataWidth-1:0] result;
  flags_t               flags;

  vector_t vectors[$];
  int      resultErrors;
  int      flagErrors;
  int      timeouts;
  bit      released;

  execCore DUT (
    .clk    (clk),
    .arstN  (arstN),
    .issue  (issue),
    .instr  (instr),
    .result (result),
    .flags  (flags)
  );

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  function automatic void addRow(
    input logic                    rowIssue,
    input opcode_t                 op,
    input logic [regAddrWidth-1:0] rowDst,
    input logic [regAddrWidth-1:0] rowSrc1,
    input logic [regAddrWidth-1:0] rowSrc2,
    input logic [dataWidth-1:0]    rowResult,
    input flags_t                  rowFlags
  );
    vector_t row;
    row.issue     = rowIssue;
    row.instr     = '{opcode: op, dst: rowDst, src1: rowSrc1, src2: rowSrc2};
    row.expResult = rowResult;
    row.expFlags  = rowFlags;
    vectors.push_back(row);
  endfunction

  task automatic fillTable();
    `include "vectorTable.svh"
  endtask

  task automatic checkResult(input int row);
    logic [dataWidth-1:0] expected;
    expected = vectors[row].expResult;
    resultMatch: assert (result === expected)
      else begin
        resultErrors++;
        $display("FAILED at %0t: row %0d %s result %h, expected %h", $time, row,
                 vectors[row].instr.opcode.name(), result, expected);
      end
  endtask

  // row is the first row that sees these flags
  task automatic checkFlags(input int row, input flags_t expected);
    flagsMatch: assert (flags === expected)
      else begin
        flagErrors++;
        $display("FAILED at %0t: flags nvz %b before row %0d, expected %b", $time,
                 flags, row, expected);
      end
  endtask

  task automatic waitResetRelease(output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < releaseTimeout) begin
      @(posedge clk);
      cycles++;
      seen = (arstN === 1'b1);
    end
    if (!seen) begin
      $display("reset release not seen within %0d cycles", releaseTimeout);
    end
  endtask

  task automatic runVectors();
    flags_t expNow;
    expNow = '0;   // flags out of reset
    for (int i = 0; i < vectors.size(); i++) begin
      @(posedge clk);
      issue <= vectors[i].issue;
      instr <= vectors[i].instr;
      @(negedge clk);   // mid cycle, result settled
      checkResult(i);
      checkFlags(i, expNow);
      expNow = vectors[i].expFlags;
    end
    // last row's flags land one edge later
    @(posedge clk);
    issue <= 1'b0;
    @(negedge clk);
    checkFlags(vectors.size(), expNow);
  endtask

  initial begin
    resultErrors = 0;
    flagErrors   = 0;
    timeouts     = 0;
    released     = 1'b0;
    arstN        = 1'b0;
    issue        = 1'b0;
    instr        = '0;

    fillTable();

    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
    waitResetRelease(released);

    if (released) begin
      runVectors();
    end else begin
      timeouts++;
    end

    $display("errors: %0d result, %0d flags, %0d timeouts over %0d rows",
             resultErrors, flagErrors, timeouts, vectors.size());
    if (resultErrors == 0 && flagErrors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+bench
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/flagReg.sv
rtl/alu.sv
rtl/execCore.sv
bench/execCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the execCore testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns \
  --top-module execCoreTb -Mdir obj_dir -f build.f

./obj_dir/VexecCoreTb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result line, see sim.log"
  exit 1
fi
echo "simulation passed"
